// File: common/bp_host_cfg.svh
// Build-time sizes for the host bridge; include in the package and in every RTL module
`ifndef BP_HOST_CFG_SVH
`define BP_HOST_CFG_SVH

`define BP_HOST_PADDR_WIDTH 40
`define BP_HOST_DATA_WIDTH 64

// 2 or 4 channels
`define BP_HOST_NUM_DMA 2
`define BP_HOST_DMA_ID_WIDTH 2

`define BP_HOST_BLOCK_OFFSET 6

// Top address bit selects the register block
`define BP_HOST_CFG_BASE_BIT (`BP_HOST_PADDR_WIDTH-1)

`define BP_HOST_CFG_REG_MASK 0
`define BP_HOST_CFG_REG_COUNT 1

`endif

// File: common/bp_host_pkg.sv
// Shared types of the host bridge; import with bp_host_pkg::* in RTL and testbench
`include "bp_host_cfg.svh"

package bp_host_pkg;

   typedef logic [`BP_HOST_PADDR_WIDTH-1:0] bp_paddr_t;
   typedef logic [`BP_HOST_DATA_WIDTH-1:0] bp_data_t;

   typedef logic [`BP_HOST_DMA_ID_WIDTH-1:0] bp_dma_id_t;
   typedef logic [(1 << `BP_HOST_DMA_ID_WIDTH)-1:0] bp_dma_mask_t;

   // Write flag in the MSB, block address below
   typedef logic [`BP_HOST_PADDR_WIDTH:0] bp_dma_pkt_t;

   typedef enum logic
   {
      e_host_read = 1'b0
      ,e_host_write = 1'b1
   } bp_host_opcode_e;

   typedef enum logic [1:0]
   {
      e_dec_idle
      ,e_dec_cfg_resp
      ,e_dec_dram_wait
      ,e_dec_resp
   } bp_decode_state_e;

   typedef enum logic [2:0]
   {
      e_fo_idle
      ,e_fo_pkt
      ,e_fo_data_out
      ,e_fo_data_in
      ,e_fo_done
   } bp_fanout_state_e;

endpackage

// File: hdl/bp_host_cfg_regs.sv
// Channel enable mask and DRAM completion counter, read and written by the command decoder
`timescale 1ns/1ps
`include "bp_host_cfg.svh"

module bp_host_cfg_regs
 import bp_host_pkg::*;
 (input                  clk_i
  , input                reset_i

  , input                cfg_w_v_i
  , input                cfg_r_v_i
  , input bp_paddr_t     cfg_addr_i
  , input bp_data_t      cfg_data_i
  , output bp_data_t     cfg_data_o

  , output bp_dma_mask_t cfg_mask_o
  , input                dram_done_v_i
  );

   localparam mask_width_lp = $bits(bp_dma_mask_t);

   bp_dma_mask_t mask_r;
   bp_data_t     count_r;

   wire sel_mask  = (cfg_addr_i == bp_paddr_t'(`BP_HOST_CFG_REG_MASK));
   wire sel_count = (cfg_addr_i == bp_paddr_t'(`BP_HOST_CFG_REG_COUNT));

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         mask_r  <= '1;  // All channels on
         count_r <= '0;
      end
      else
      begin
         if (cfg_w_v_i & sel_mask)
            mask_r <= cfg_data_i[mask_width_lp-1:0];

         if (cfg_w_v_i & sel_count)
            count_r <= '0;  // Any write clears
         else if (dram_done_v_i)
            count_r <= count_r + 1'b1;
      end
   end

   always_comb
   begin
      cfg_data_o = '0;  // Unknown offsets read zero
      if (cfg_r_v_i)
      begin
         if (sel_mask)
            cfg_data_o = bp_data_t'(mask_r);
         else if (sel_count)
            cfg_data_o = count_r;
      end
   end

   assign cfg_mask_o = mask_r;

endmodule

// File: hdl/bp_host_cmd_decode.sv
// Takes host commands, steers them to the register block or the DMA fanout, returns responses
`timescale 1ns/1ps
`include "bp_host_cfg.svh"

module bp_host_cmd_decode
 import bp_host_pkg::*;
 (input                     clk_i
  , input                   reset_i

  , input                   io_cmd_v_i
  , input bp_host_opcode_e  io_cmd_opcode_i
  , input bp_paddr_t        io_cmd_addr_i
  , input bp_data_t         io_cmd_data_i
  , output logic            io_cmd_yumi_o

  , output logic            io_resp_v_o
  , output bp_data_t        io_resp_data_o
  , output logic            io_resp_err_o
  , input                   io_resp_ready_and_i

  , output logic            cfg_w_v_o
  , output logic            cfg_r_v_o
  , output bp_paddr_t       cfg_addr_o
  , output bp_data_t        cfg_data_o
  , input bp_data_t         cfg_data_i
  , input bp_dma_mask_t     cfg_mask_i
  , output logic            dram_done_v_o

  , output logic            req_v_o
  , output bp_host_opcode_e req_opcode_o
  , output bp_paddr_t       req_addr_o
  , output bp_data_t        req_data_o
  , output bp_dma_id_t      req_id_o
  , input                   req_ready_i
  , input                   done_v_i
  , input bp_data_t         done_data_i
  );

   localparam id_bits_lp   = $clog2(`BP_HOST_NUM_DMA);
   localparam word_bits_lp = $clog2(`BP_HOST_DATA_WIDTH/8);

   bp_decode_state_e state_r, state_n;
   bp_data_t         resp_data_r;
   logic             resp_err_r;
   logic             take;

   wire is_cfg = io_cmd_addr_i[`BP_HOST_CFG_BASE_BIT];
   wire is_wr  = (io_cmd_opcode_i == e_host_write);

   // Interleave on the bits just above the block offset
   assign req_id_o = bp_dma_id_t'(io_cmd_addr_i[`BP_HOST_BLOCK_OFFSET+:id_bits_lp]);
   wire ch_en      = cfg_mask_i[req_id_o];

   assign take = (state_r == e_dec_idle) & io_cmd_v_i & (is_cfg | ~ch_en | req_ready_i);

   assign io_cmd_yumi_o = take;
   assign cfg_w_v_o     = take & is_cfg & is_wr;
   assign cfg_r_v_o     = take & is_cfg & ~is_wr;
   assign cfg_addr_o    = bp_paddr_t'(io_cmd_addr_i[`BP_HOST_CFG_BASE_BIT-1:word_bits_lp]);
   assign cfg_data_o    = io_cmd_data_i;

   assign req_v_o       = take & ~is_cfg & ch_en;
   assign req_opcode_o  = io_cmd_opcode_i;
   assign req_addr_o    = io_cmd_addr_i;
   assign req_data_o    = io_cmd_data_i;

   assign dram_done_v_o  = (state_r == e_dec_dram_wait) & done_v_i;
   assign io_resp_v_o    = (state_r == e_dec_cfg_resp) | (state_r == e_dec_resp);
   assign io_resp_data_o = resp_data_r;
   assign io_resp_err_o  = resp_err_r;

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         e_dec_idle:
            if (take)
               state_n = is_cfg ? e_dec_cfg_resp : (ch_en ? e_dec_dram_wait : e_dec_resp);
         e_dec_dram_wait:
            if (done_v_i)
               state_n = e_dec_resp;
         e_dec_cfg_resp, e_dec_resp:
            if (io_resp_ready_and_i)
               state_n = e_dec_idle;
         default:
            state_n = e_dec_idle;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         state_r <= e_dec_idle;
      else
         state_r <= state_n;
   end

   always_ff @(posedge clk_i)
   begin
      if (take)
      begin
         resp_data_r <= is_cfg ? cfg_data_i : '0;
         resp_err_r  <= ~is_cfg & ~ch_en;  // Masked channel
      end
      else if (dram_done_v_o)
      begin
         resp_data_r <= done_data_i;
         resp_err_r  <= 1'b0;
      end
   end

   a_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      io_resp_v_o && !io_resp_ready_and_i |=>
         io_resp_v_o && $stable(io_resp_data_o) && $stable(io_resp_err_o));

endmodule

// File: dma/bp_host_dma_fanout.sv
// Runs one DRAM request as a cache DMA packet and data exchange on the chosen channel
`timescale 1ns/1ps
`include "bp_host_cfg.svh"

module bp_host_dma_fanout
 import bp_host_pkg::*;
 (input                                              clk_i
  , input                                            reset_i

  , input                                            req_v_i
  , input bp_host_opcode_e                           req_opcode_i
  , input bp_paddr_t                                 req_addr_i
  , input bp_data_t                                  req_data_i
  , input bp_dma_id_t                                req_id_i
  , output logic                                     req_ready_o

  , output logic                                     done_v_o
  , output bp_data_t                                 done_data_o

  , output bp_dma_pkt_t [`BP_HOST_NUM_DMA-1:0]       dma_pkt_o
  , output logic [`BP_HOST_NUM_DMA-1:0]              dma_pkt_v_o
  , input [`BP_HOST_NUM_DMA-1:0]                     dma_pkt_yumi_i

  , input bp_data_t [`BP_HOST_NUM_DMA-1:0]           dma_data_i
  , input [`BP_HOST_NUM_DMA-1:0]                     dma_data_v_i
  , output logic [`BP_HOST_NUM_DMA-1:0]              dma_data_ready_and_o

  , output bp_data_t [`BP_HOST_NUM_DMA-1:0]          dma_data_o
  , output logic [`BP_HOST_NUM_DMA-1:0]              dma_data_v_o
  , input [`BP_HOST_NUM_DMA-1:0]                     dma_data_yumi_i
  );

   localparam num_dma_lp    = `BP_HOST_NUM_DMA;
   localparam block_off_lp  = `BP_HOST_BLOCK_OFFSET;
   localparam paddr_width_lp = `BP_HOST_PADDR_WIDTH;

   bp_fanout_state_e state_r, state_n;

   logic       wr_r;
   bp_paddr_t  addr_r;
   bp_data_t   wdata_r;
   bp_data_t   rdata_r;
   bp_dma_id_t id_r;

   logic [num_dma_lp-1:0] sel;
   logic                  pkt_yumi, data_yumi, data_v;

   assign sel       = num_dma_lp'(1) << id_r;  // One-hot channel select
   assign pkt_yumi  = |(dma_pkt_yumi_i & sel);
   assign data_yumi = |(dma_data_yumi_i & sel);
   assign data_v    = |(dma_data_v_i & sel);

   assign req_ready_o = (state_r == e_fo_idle);
   assign done_v_o    = (state_r == e_fo_done);
   assign done_data_o = rdata_r;

   assign dma_pkt_v_o          = sel & {num_dma_lp{state_r == e_fo_pkt}};
   assign dma_data_v_o         = sel & {num_dma_lp{state_r == e_fo_data_out}};
   assign dma_data_ready_and_o = sel & {num_dma_lp{state_r == e_fo_data_in}};

   for (genvar i = 0; i < num_dma_lp; i++)
   begin : chan
      assign dma_pkt_o[i]  = {wr_r, addr_r};
      assign dma_data_o[i] = wdata_r;
   end

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         e_fo_idle:
            if (req_v_i)
               state_n = e_fo_pkt;
         e_fo_pkt:
            if (pkt_yumi)
               state_n = wr_r ? e_fo_data_out : e_fo_data_in;
         e_fo_data_out:
            if (data_yumi)
               state_n = e_fo_done;
         e_fo_data_in:
            if (data_v)
               state_n = e_fo_done;
         e_fo_done:
            state_n = e_fo_idle;  // Single-cycle done pulse
         default:
            state_n = e_fo_idle;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         state_r <= e_fo_idle;
      else
         state_r <= state_n;
   end

   always_ff @(posedge clk_i)
   begin
      if (req_v_i & req_ready_o)
      begin
         wr_r    <= (req_opcode_i == e_host_write);
         addr_r  <= {req_addr_i[paddr_width_lp-1:block_off_lp], block_off_lp'(0)};
         wdata_r <= req_data_i;
         id_r    <= req_id_i;
         rdata_r <= '0;  // Writes return zero
      end
      else if ((state_r == e_fo_data_in) & data_v)
      begin
         rdata_r <= dma_data_i[id_r];
      end
   end

   // Exactly one channel while busy
   a_one_channel: assert property (@(posedge clk_i) disable iff (reset_i)
      (state_r inside {e_fo_pkt, e_fo_data_out, e_fo_data_in})
         |-> $onehot(dma_pkt_v_o | dma_data_v_o | dma_data_ready_and_o));

endmodule

// File: hdl/bp_host_wrapper.sv
// Top level of the host bridge; connects host I/O ports to the register block and DRAM channels
`timescale 1ns/1ps
`include "bp_host_cfg.svh"

module bp_host_wrapper
 import bp_host_pkg::*;
 (input                                              clk_i
  , input                                            reset_i

  , input                                            io_cmd_v_i
  , input bp_host_opcode_e                           io_cmd_opcode_i
  , input bp_paddr_t                                 io_cmd_addr_i
  , input bp_data_t                                  io_cmd_data_i
  , output logic                                     io_cmd_yumi_o

  , output logic                                     io_resp_v_o
  , output bp_data_t                                 io_resp_data_o
  , output logic                                     io_resp_err_o
  , input                                            io_resp_ready_and_i

  , output bp_dma_pkt_t [`BP_HOST_NUM_DMA-1:0]       dma_pkt_o
  , output logic [`BP_HOST_NUM_DMA-1:0]              dma_pkt_v_o
  , input [`BP_HOST_NUM_DMA-1:0]                     dma_pkt_yumi_i

  , input bp_data_t [`BP_HOST_NUM_DMA-1:0]           dma_data_i
  , input [`BP_HOST_NUM_DMA-1:0]                     dma_data_v_i
  , output logic [`BP_HOST_NUM_DMA-1:0]              dma_data_ready_and_o

  , output bp_data_t [`BP_HOST_NUM_DMA-1:0]          dma_data_o
  , output logic [`BP_HOST_NUM_DMA-1:0]              dma_data_v_o
  , input [`BP_HOST_NUM_DMA-1:0]                     dma_data_yumi_i
  );

   logic            cfg_w_v, cfg_r_v, dram_done_v;
   bp_paddr_t       cfg_addr;
   bp_data_t        cfg_wdata, cfg_rdata;
   bp_dma_mask_t    cfg_mask;

   logic            req_v, req_ready, done_v;
   bp_host_opcode_e req_opcode;
   bp_paddr_t       req_addr;
   bp_data_t        req_data, done_data;
   bp_dma_id_t      req_id;

   bp_host_cmd_decode cmd_decode
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.io_cmd_v_i(io_cmd_v_i)
       ,.io_cmd_opcode_i(io_cmd_opcode_i)
       ,.io_cmd_addr_i(io_cmd_addr_i)
       ,.io_cmd_data_i(io_cmd_data_i)
       ,.io_cmd_yumi_o(io_cmd_yumi_o)
       ,.io_resp_v_o(io_resp_v_o)
       ,.io_resp_data_o(io_resp_data_o)
       ,.io_resp_err_o(io_resp_err_o)
       ,.io_resp_ready_and_i(io_resp_ready_and_i)
       ,.cfg_w_v_o(cfg_w_v)
       ,.cfg_r_v_o(cfg_r_v)
       ,.cfg_addr_o(cfg_addr)
       ,.cfg_data_o(cfg_wdata)
       ,.cfg_data_i(cfg_rdata)
       ,.cfg_mask_i(cfg_mask)
       ,.dram_done_v_o(dram_done_v)
       ,.req_v_o(req_v)
       ,.req_opcode_o(req_opcode)
       ,.req_addr_o(req_addr)
       ,.req_data_o(req_data)
       ,.req_id_o(req_id)
       ,.req_ready_i(req_ready)
       ,.done_v_i(done_v)
       ,.done_data_i(done_data)
       );

   bp_host_cfg_regs cfg_regs
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.cfg_w_v_i(cfg_w_v)
       ,.cfg_r_v_i(cfg_r_v)
       ,.cfg_addr_i(cfg_addr)
       ,.cfg_data_i(cfg_wdata)
       ,.cfg_data_o(cfg_rdata)
       ,.cfg_mask_o(cfg_mask)
       ,.dram_done_v_i(dram_done_v)
       );

   bp_host_dma_fanout dma_fanout
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.req_v_i(req_v)
       ,.req_opcode_i(req_opcode)
       ,.req_addr_i(req_addr)
       ,.req_data_i(req_data)
       ,.req_id_i(req_id)
       ,.req_ready_o(req_ready)
       ,.done_v_o(done_v)
       ,.done_data_o(done_data)
       ,.dma_pkt_o(dma_pkt_o)
       ,.dma_pkt_v_o(dma_pkt_v_o)
       ,.dma_pkt_yumi_i(dma_pkt_yumi_i)
       ,.dma_data_i(dma_data_i)
       ,.dma_data_v_i(dma_data_v_i)
       ,.dma_data_ready_and_o(dma_data_ready_and_o)
       ,.dma_data_o(dma_data_o)
       ,.dma_data_v_o(dma_data_v_o)
       ,.dma_data_yumi_i(dma_data_yumi_i)
       );

endmodule

// File: verif/tb_clk_gen.sv
// Clock and reset source for the host bridge testbench; instantiate once in the testbench top
`timescale 1ns/1ps

module tb_clk_gen
 #(parameter int half_period_p = 5
   , parameter int reset_cycles_p = 8
   )
 (output logic clk_o
  , output logic reset_o
  );

   initial
   begin
      clk_o   = 1'b0;
      reset_o = 1'b1;
      repeat (reset_cycles_p) @(posedge clk_o);
      #1 reset_o = 1'b0;  // Released just after the edge
   end

   always #(half_period_p) clk_o = ~clk_o;

endmodule

// File: verif/tb_bp_host_wrapper.sv
// Directed testbench for the host bridge; drives host commands and models the DRAM channels
`timescale 1ns/1ps
`include "bp_host_cfg.svh"

module tb_bp_host_wrapper
 import bp_host_pkg::*;
 ();

   localparam int num_dma_lp        = `BP_HOST_NUM_DMA;
   localparam int word_bytes_lp     = `BP_HOST_DATA_WIDTH/8;
   localparam int num_ops_lp        = 8;
   localparam int timeout_cycles_lp = 2000;  // About 4x the full run

   logic clk, reset;

   logic            io_cmd_v_i;
   bp_host_opcode_e io_cmd_opcode_i;
   bp_paddr_t       io_cmd_addr_i;
   bp_data_t        io_cmd_data_i;
   logic            io_cmd_yumi_o;
   logic            io_resp_v_o;
   bp_data_t        io_resp_data_o;
   logic            io_resp_err_o;
   logic            io_resp_ready_and_i;

   bp_dma_pkt_t [num_dma_lp-1:0] dma_pkt_o;
   logic [num_dma_lp-1:0]        dma_pkt_v_o, dma_pkt_yumi_i;
   bp_data_t [num_dma_lp-1:0]    dma_data_i;
   logic [num_dma_lp-1:0]        dma_data_v_i, dma_data_ready_and_o;
   bp_data_t [num_dma_lp-1:0]    dma_data_o;
   logic [num_dma_lp-1:0]        dma_data_v_o, dma_data_yumi_i;

   int         errors = 0;
   int         checks = 0;
   int         cycle_count = 0;
   int         pkt_total = 0;
   int         active_cycles [num_dma_lp];
   bp_data_t   expected_count = '0;
   bp_data_t   dram_mem [num_dma_lp][bp_paddr_t];
   bp_data_t   written [bp_paddr_t];
   bp_paddr_t  used_addr [num_ops_lp];
   bp_paddr_t  last_addr;
   logic       last_wr;
   bp_dma_id_t last_id;

   tb_clk_gen clk_gen
      (.clk_o(clk)
       ,.reset_o(reset)
       );

   bp_host_wrapper bp_host_wrapper_inst
      (.clk_i(clk)
       ,.reset_i(reset)
       ,.*
       );

   task automatic flag_error(input string msg);
      errors++;
      $display("[FAIL] %0d ns: %s", $time, msg);
   endtask

   task automatic check_data(input bp_data_t got, input bp_data_t exp, input string what);
      checks++;
      if (got !== exp)
         flag_error($sformatf("%s: got %h, expected %h", what, got, exp));
   endtask

   task automatic check_err(input bit got, input bit exp, input string what);
      checks++;
      if (got != exp)
         flag_error($sformatf("%s: got %0b, expected %0b", what, got, exp));
   endtask

   task automatic check_id(input bp_dma_id_t got, input bp_dma_id_t exp, input string what);
      checks++;
      if (got !== exp)
         flag_error($sformatf("%s: got channel %0d, expected %0d", what, got, exp));
   endtask

   task automatic check_count(input bp_data_t got, input bp_data_t exp, input string what);
      checks++;
      if (got !== exp)
         flag_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
   endtask

   // Consecutive blocks rotate over the channels
   function automatic bp_dma_id_t channel_of(input bp_paddr_t addr);
      return bp_dma_id_t'((addr >> `BP_HOST_BLOCK_OFFSET) % num_dma_lp);
   endfunction

   function automatic bp_paddr_t block_of(input bp_paddr_t addr);
      return (addr >> `BP_HOST_BLOCK_OFFSET) << `BP_HOST_BLOCK_OFFSET;
   endfunction

   function automatic bp_paddr_t cfg_addr(input int offset);
      return (bp_paddr_t'(1) << `BP_HOST_CFG_BASE_BIT) | bp_paddr_t'(offset * word_bytes_lp);
   endfunction

   function automatic bp_paddr_t dram_addr(input bp_dma_id_t ch);
      bp_paddr_t a;
      a = bp_paddr_t'({$urandom, $urandom});
      a[`BP_HOST_CFG_BASE_BIT] = 1'b0;
      a[`BP_HOST_BLOCK_OFFSET +: $clog2(num_dma_lp)] = ch[$clog2(num_dma_lp)-1:0];
      return a;
   endfunction

   // DRAM channel model acting 1 ns after each edge
   initial
   begin
      int pkt_delay [num_dma_lp];
      int data_delay [num_dma_lp];
      bp_paddr_t pkt_addr [num_dma_lp];
      dma_pkt_yumi_i  = '0;
      dma_data_yumi_i = '0;
      dma_data_v_i    = '0;
      dma_data_i      = '0;
      @(negedge reset);
      for (int c = 0; c < num_dma_lp; c++)
      begin
         active_cycles[c] = 0;
         pkt_delay[c]     = $urandom_range(3);
         data_delay[c]    = $urandom_range(3);
      end
      forever
      begin
         @(posedge clk);
         #1;
         for (int c = 0; c < num_dma_lp; c++)
         begin
            dma_pkt_yumi_i[c]  = 1'b0;
            dma_data_yumi_i[c] = 1'b0;
            dma_data_v_i[c]    = 1'b0;
            if (dma_pkt_v_o[c] | dma_data_v_o[c] | dma_data_ready_and_o[c])
               active_cycles[c]++;
            if (dma_pkt_v_o[c])
            begin
               if (pkt_delay[c] == 0)
               begin
                  dma_pkt_yumi_i[c] = 1'b1;
                  pkt_addr[c]       = dma_pkt_o[c][`BP_HOST_PADDR_WIDTH-1:0];
                  last_wr           = dma_pkt_o[c][`BP_HOST_PADDR_WIDTH];
                  last_addr         = pkt_addr[c];
                  last_id           = bp_dma_id_t'(c);
                  pkt_total++;
                  pkt_delay[c]      = $urandom_range(3);
               end
               else
                  pkt_delay[c]--;
            end
            if (dma_data_v_o[c] | dma_data_ready_and_o[c])
            begin
               if (data_delay[c] != 0)
                  data_delay[c]--;
               else if (dma_data_v_o[c])
               begin
                  dma_data_yumi_i[c] = 1'b1;
                  dram_mem[c][pkt_addr[c]] = dma_data_o[c];
                  data_delay[c] = $urandom_range(3);
               end
               else
               begin
                  dma_data_v_i[c] = 1'b1;
                  dma_data_i[c]   = dram_mem[c].exists(pkt_addr[c])
                                    ? dram_mem[c][pkt_addr[c]] : '0;
                  data_delay[c]   = $urandom_range(3);
               end
            end
         end
      end
   end

   // Starts and ends 1 ns after an edge; lat counts cycles from take to response
   task automatic host_access(input bp_host_opcode_e op, input bp_paddr_t addr,
                              input bp_data_t wdata, input int stall_max, input bit hold_cmd,
                              output bp_data_t rdata, output logic err, output int lat);
      bit taken;
      bit got;
      bit done;
      int stall;
      taken = 1'b0;
      got   = 1'b0;
      done  = 1'b0;
      lat   = 0;
      stall = $urandom_range(stall_max);
      io_cmd_v_i      = 1'b1;
      io_cmd_opcode_i = op;
      io_cmd_addr_i   = addr;
      io_cmd_data_i   = wdata;
      while (!taken)
      begin
         @(negedge clk);
         taken = io_cmd_yumi_o;
         @(posedge clk);
         #1;
      end
      io_cmd_v_i          = hold_cmd;  // Same command offered again
      io_resp_ready_and_i = (stall == 0);
      while (!done)
      begin
         @(negedge clk);
         if (io_cmd_yumi_o)
            flag_error("command taken while a response was pending");
         if (!got)
            lat++;
         if (io_resp_v_o & !got)
         begin
            got   = 1'b1;
            rdata = io_resp_data_o;
            err   = io_resp_err_o;
         end
         else if (io_resp_v_o)
         begin
            check_data(io_resp_data_o, rdata, "held response data");
            check_err(io_resp_err_o, err, "held response error");
         end
         done = io_resp_v_o & io_resp_ready_and_i;
         @(posedge clk);
         #1;
         if (got && stall > 0)
            stall--;
         io_resp_ready_and_i = (stall == 0);
      end
      io_cmd_v_i          = 1'b0;
      io_resp_ready_and_i = 1'b0;
   endtask

   task automatic cfg_read(input int offset, output bp_data_t value);
      logic err;
      int lat;
      host_access(e_host_read, cfg_addr(offset), '0, 0, 1'b0, value, err, lat);
      check_err(err, 1'b0, "register read error");
      if (lat != 1)
         flag_error($sformatf("register read answered after %0d cycles", lat));
   endtask

   task automatic cfg_write(input int offset, input bp_data_t value);
      bp_data_t rdata;
      logic err;
      int lat;
      host_access(e_host_write, cfg_addr(offset), value, 0, 1'b0, rdata, err, lat);
      check_err(err, 1'b0, "register write error");
      if (lat != 1)
         flag_error($sformatf("register write answered after %0d cycles", lat));
   endtask

   task automatic dram_access(input bp_host_opcode_e op, input bp_paddr_t addr,
                              input bp_data_t wdata, input int stall_max, input bit hold_cmd);
      bp_data_t rdata;
      logic err;
      int lat;
      int pkts_before;
      bp_paddr_t blk;
      blk = block_of(addr);
      pkts_before = pkt_total;
      host_access(op, addr, wdata, stall_max, hold_cmd, rdata, err, lat);
      check_err(err, 1'b0, "DRAM response error");
      check_count(bp_data_t'(pkt_total - pkts_before), 1, "packets per DRAM access");
      check_id(last_id, channel_of(addr), "packet channel");
      check_data(bp_data_t'(last_addr), bp_data_t'(blk), "packet block address");
      check_err(last_wr, op == e_host_write, "packet write flag");
      if (op == e_host_write)
         written[blk] = wdata;
      else
         check_data(rdata, written.exists(blk) ? written[blk] : '0, "DRAM read data");
      expected_count++;
   endtask

   task automatic test_reset();
      bp_data_t value;
      @(negedge clk);
      check_err(io_cmd_yumi_o, 1'b0, "yumi after reset");
      check_err(io_resp_v_o, 1'b0, "response valid after reset");
      check_err(|dma_pkt_v_o, 1'b0, "packet valid after reset");
      check_err(|dma_data_v_o, 1'b0, "data valid after reset");
      check_err(|dma_data_ready_and_o, 1'b0, "data ready after reset");
      @(posedge clk);
      #1;
      cfg_read(`BP_HOST_CFG_REG_MASK, value);
      check_data(value, bp_data_t'(bp_dma_mask_t'('1)), "mask after reset");
      cfg_read(`BP_HOST_CFG_REG_COUNT, value);
      check_count(value, '0, "counter after reset");
   endtask

   task automatic test_mask_rw();
      bp_data_t value;
      int pkts_before;
      pkts_before = pkt_total;
      cfg_write(`BP_HOST_CFG_REG_MASK, 'ha);
      cfg_read(`BP_HOST_CFG_REG_MASK, value);
      check_data(value, 'ha, "mask readback");
      cfg_write(`BP_HOST_CFG_REG_MASK, bp_data_t'(bp_dma_mask_t'('1)));
      cfg_read(`BP_HOST_CFG_REG_MASK, value);
      check_data(value, bp_data_t'(bp_dma_mask_t'('1)), "mask restored");
      check_count(bp_data_t'(pkt_total - pkts_before), '0, "packets during register access");
   endtask

   task automatic test_dram_rw();
      for (int i = 0; i < num_ops_lp; i++)
      begin
         used_addr[i] = dram_addr(bp_dma_id_t'(i % num_dma_lp));
         dram_access(e_host_write, used_addr[i], {$urandom, $urandom}, 0, 1'b0);
      end
      for (int i = 0; i < num_ops_lp; i++)
         dram_access(e_host_read, used_addr[i], '0, 0, 1'b0);
   endtask

   task automatic test_disabled_channel();
      bp_dma_id_t off_ch;
      bp_data_t rdata;
      logic err;
      int lat;
      int active_before;
      off_ch = bp_dma_id_t'(num_dma_lp - 1);
      cfg_write(`BP_HOST_CFG_REG_MASK, bp_data_t'(~(bp_dma_mask_t'(1) << off_ch)));
      active_before = active_cycles[off_ch];
      host_access(e_host_read, dram_addr(off_ch), '0, 0, 1'b0, rdata, err, lat);
      check_err(err, 1'b1, "read on disabled channel");
      if (lat != 1)
         flag_error($sformatf("disabled channel answered after %0d cycles", lat));
      host_access(e_host_write, dram_addr(off_ch), '1, 3, 1'b0, rdata, err, lat);
      check_err(err, 1'b1, "write on disabled channel");
      check_count(bp_data_t'(active_cycles[off_ch] - active_before), '0,
                  "cycles with activity on disabled channel");
      dram_access(e_host_read, used_addr[0], '0, 0, 1'b0);  // Channel 0 still open
      cfg_write(`BP_HOST_CFG_REG_MASK, bp_data_t'(bp_dma_mask_t'('1)));
   endtask

   task automatic test_backpressure();
      bp_data_t rdata;
      logic err;
      int lat;
      for (int i = 0; i < num_ops_lp; i++)
         dram_access(e_host_read, used_addr[i], '0, 6, 1'b1);
      host_access(e_host_read, cfg_addr(`BP_HOST_CFG_REG_MASK), '0, 6, 1'b1, rdata, err, lat);
      check_data(rdata, bp_data_t'(bp_dma_mask_t'('1)), "mask read under stall");
   endtask

   task automatic test_counter();
      bp_data_t value;
      cfg_read(`BP_HOST_CFG_REG_COUNT, value);
      check_count(value, expected_count, "completed DRAM operations");
      cfg_write(`BP_HOST_CFG_REG_COUNT, 'h1234);  // Any write clears
      expected_count = '0;
      cfg_read(`BP_HOST_CFG_REG_COUNT, value);
      check_count(value, expected_count, "counter after clear");
      dram_access(e_host_write, used_addr[1], {$urandom, $urandom}, 2, 1'b0);
      dram_access(e_host_read, used_addr[1], '0, 2, 1'b0);
      cfg_read(`BP_HOST_CFG_REG_COUNT, value);
      check_count(value, expected_count, "counter after two operations");
   endtask

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= timeout_cycles_lp)
      begin
         $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles_lp);
         $display("checks: %0d, errors: %0d", checks, errors);
         $display("=== FAIL ===");
         $finish;
      end
   end

   initial
   begin
      void'($urandom(32'hc8c0_d9ec));
      io_cmd_v_i          = 1'b0;
      io_cmd_opcode_i     = e_host_read;
      io_cmd_addr_i       = '0;
      io_cmd_data_i       = '0;
      io_resp_ready_and_i = 1'b0;
      @(negedge reset);
      test_reset();
      test_mask_rw();
      test_dram_rw();
      test_disabled_channel();
      test_backpressure();
      test_counter();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: project.f
+incdir+common
common/bp_host_pkg.sv
hdl/bp_host_cfg_regs.sv
hdl/bp_host_cmd_decode.sv
dma/bp_host_dma_fanout.sv
hdl/bp_host_wrapper.sv
verif/tb_clk_gen.sv
verif/tb_bp_host_wrapper.sv

// File: Bender.yml
package:
  name: bp_host_bridge

sources:
  - include_dirs:
      - common
    files:
      - common/bp_host_pkg.sv
      - hdl/bp_host_cfg_regs.sv
      - hdl/bp_host_cmd_decode.sv
      - dma/bp_host_dma_fanout.sv
      - hdl/bp_host_wrapper.sv

  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_bp_host_wrapper.sv
